//--- dv/cic_arbiter_checker.sv
// output handshake rules and result accounting for cic_output_arbiter; active only while arst_n is high
`timescale 1ns/10ps

module cic_arbiter_checker (
  input  logic                clock,
  input  logic                arst_n,
  input  cic_pkg::chan_mask_t res_strobe,
  input  logic                out_valid,
  input  logic                out_ready,
  input  cic_pkg::chan_t      out_channel,
  input  cic_pkg::result_t    out_data,
  input  cic_pkg::chan_mask_t drop_pulse
);

  // results of a channel inside the arbiter, hold slot plus output register
  int held [cic_pkg::n_channels];

  // --------------------------------------------------------------------------
  // valid/ready stream
  // --------------------------------------------------------------------------
  // a presented item waits for its transfer
  valid_held: assert property (@(posedge clock) disable iff (!arst_n)
    (out_valid && !out_ready) |=> out_valid)
    else $error("out_valid fell before the item was accepted");

  // payload frozen during a stall
  payload_stable: assert property (@(posedge clock) disable iff (!arst_n)
    (out_valid && !out_ready) |=> ($stable(out_data) && $stable(out_channel)))
    else $error("out_data or out_channel changed while stalled");

  // --------------------------------------------------------------------------
  // drops
  // --------------------------------------------------------------------------
  // arrivals minus drops minus transfers, per channel
  always_ff @(posedge clock or negedge arst_n)
  begin
    if (!arst_n)
    begin
      for (int i = 0; i < cic_pkg::n_channels; i++)
        held[i] <= 0;
    end
    else
    begin
      for (int i = 0; i < cic_pkg::n_channels; i++)
        held[i] <= held[i] + int'(res_strobe[i]) - int'(drop_pulse[i]) -
                   int'(out_valid && out_ready && (out_channel == cic_pkg::chan_t'(i)));
    end
  end

  // a drop from an empty slot drives the count below zero
  // an unreported loss pushes it above two
  for (genvar c = 0; c < cic_pkg::n_channels; c++)
  begin : g_held
    held_in_range: assert property (@(posedge clock) disable iff (!arst_n)
      (held[c] >= 0) && (held[c] <= 2))
      else $error("result accounting of channel %0d out of range", c);
  end

endmodule

bind cic_output_arbiter cic_arbiter_checker i_cic_arbiter_checker (
  .clock       (clock),
  .arst_n      (arst_n),
  .res_strobe  (res_strobe),
  .out_valid   (out_valid),
  .out_ready   (out_ready),
  .out_channel (out_channel),
  .out_data    (out_data),
  .drop_pulse  (drop_pulse)
);

//--- dv/cic_rx_tb.sv
// directed tests; out_ready is high except in the drop test, the run stops at a fixed cycle limit
`timescale 1ns/10ps

module cic_rx_tb;

  // --------------------------------------------------------------------------
  // run length
  // --------------------------------------------------------------------------
  localparam int dc_outputs     = 8;
  localparam int gain_samples   = (32 + 16 + 8 + 8) * dc_outputs;
  localparam int count_samples  = 128;
  localparam int iso_rounds     = 256;
  localparam int settle_samples = 64;
  localparam int stall_samples  = 48;
  localparam int total_samples  = gain_samples + count_samples + 4 * iso_rounds +
                                  settle_samples + stall_samples;
  localparam int timeout_cycles = 2 * total_samples + 2000;
  // quiet time after the expected outputs, catches surplus ones
  localparam int drain_cycles   = 64;

  logic                clock = 1'b0;
  logic                arst_n;
  logic                psel;
  logic                penable;
  logic                pwrite;
  cic_pkg::paddr_t     paddr;
  cic_pkg::apb_data_t  pwdata;
  cic_pkg::apb_data_t  prdata;
  logic                pready;
  logic                pslverr;
  logic                in_valid;
  cic_pkg::chan_t      in_channel;
  cic_pkg::sample_t    in_data;
  logic                out_valid;
  logic                out_ready;
  cic_pkg::chan_t      out_channel;
  cic_pkg::result_t    out_data;

  cic_pkg::chan_t      got_chan [$];
  cic_pkg::result_t    got_data [$];
  int                  error_count = 0;
  int                  check_total = 0;
  int                  cycle_count = 0;

  cic_rx_top i_cic_rx_top (
    .clock       (clock),
    .arst_n      (arst_n),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .paddr       (paddr),
    .pwdata      (pwdata),
    .prdata      (prdata),
    .pready      (pready),
    .pslverr     (pslverr),
    .in_valid    (in_valid),
    .in_channel  (in_channel),
    .in_data     (in_data),
    .out_valid   (out_valid),
    .out_ready   (out_ready),
    .out_channel (out_channel),
    .out_data    (out_data)
  );

  // 40 ns period
  always #20 clock = ~clock;

  // hard stop on a hung run
  always @(posedge clock)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_cycles)
    begin
      $display("timeout: no finish after %0d clock cycles", timeout_cycles);
      $display("Simulation failed");
      $finish;
    end
  end

  // --------------------------------------------------------------------------
  // expected values
  // --------------------------------------------------------------------------
  function automatic int factor_of(input cic_pkg::rate_t r);
    case (r)
      2'd0:    return 32;
      2'd1:    return 16;
      default: return 8;
    endcase
  endfunction

  // settled dc output is twice the input at every rate
  function automatic cic_pkg::result_t dc_level(input cic_pkg::sample_t x);
    return cic_pkg::result_t'(2 * int'(x));
  endfunction

  // --------------------------------------------------------------------------
  // compare tasks
  // --------------------------------------------------------------------------
  task automatic check_result(input cic_pkg::result_t got, input cic_pkg::result_t exp,
                              input string what);
    check_total++;
    if (got !== exp)
    begin
      error_count++;
      $display("CHECK FAILED at %0t: %s, got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_chan(input cic_pkg::chan_t got, input cic_pkg::chan_t exp,
                            input string what);
    check_total++;
    if (got !== exp)
    begin
      error_count++;
      $display("CHECK FAILED at %0t: %s, got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_reg(input cic_pkg::apb_data_t got, input cic_pkg::apb_data_t exp,
                           input string what);
    check_total++;
    if (got !== exp)
    begin
      error_count++;
      $display("CHECK FAILED at %0t: %s, got %08h expected %08h", $time, what, got, exp);
    end
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    check_total++;
    if (got != exp)
    begin
      error_count++;
      $display("CHECK FAILED at %0t: %s, got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  // --------------------------------------------------------------------------
  // bus and stream tasks
  // --------------------------------------------------------------------------
  task automatic apb_write(input cic_pkg::paddr_t addr, input cic_pkg::apb_data_t data);
    @(posedge clock);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b1;
    paddr   <= addr;
    pwdata  <= data;
    @(posedge clock);
    penable <= 1'b1;
    // zero wait states, pready up in the access phase
    @(negedge clock);
    check_reg(cic_pkg::apb_data_t'(pready), 32'h1, "pready on write");
    @(posedge clock);
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
  endtask

  task automatic apb_read(input cic_pkg::paddr_t addr, output cic_pkg::apb_data_t data,
                          output logic err);
    @(posedge clock);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    paddr   <= addr;
    @(posedge clock);
    penable <= 1'b1;
    // access phase, sampled mid cycle
    @(negedge clock);
    check_reg(cic_pkg::apb_data_t'(pready), 32'h1, "pready on read");
    data = prdata;
    err  = pslverr;
    @(posedge clock);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic send_sample(input cic_pkg::chan_t ch, input cic_pkg::sample_t x);
    @(posedge clock);
    in_valid   <= 1'b1;
    in_channel <= ch;
    in_data    <= x;
  endtask

  task automatic stop_input;
    @(posedge clock);
    in_valid <= 1'b0;
  endtask

  // one entry per transfer, valid and ready seen mid cycle
  task automatic collect_outputs;
    forever
    begin
      @(negedge clock);
      if (arst_n && out_valid && out_ready)
      begin
        got_chan.push_back(out_channel);
        got_data.push_back(out_data);
      end
    end
  endtask

  task automatic clear_outputs;
    got_chan.delete();
    got_data.delete();
  endtask

  task automatic wait_outputs(input int n);
    while (got_data.size() < n)
      @(posedge clock);
    repeat (drain_cycles) @(posedge clock);
  endtask

  initial collect_outputs();

  // --------------------------------------------------------------------------
  // directed tests
  // --------------------------------------------------------------------------
  task automatic register_access;
    cic_pkg::apb_data_t data;
    logic               err;
    apb_write(cic_pkg::addr_ctrl, 32'h0000_0005);
    apb_read(cic_pkg::addr_ctrl, data, err);
    check_reg(data, 32'h0000_0005, "ctrl readback");
    check_reg(cic_pkg::apb_data_t'(err), 32'h0, "pslverr on ctrl read");
    // only the low 8 bits exist
    apb_write(cic_pkg::addr_rate, 32'hffff_ffe4);
    apb_read(cic_pkg::addr_rate, data, err);
    check_reg(data, 32'h0000_00e4, "rate readback");
    apb_write(4'hc, 32'hffff_ffff);
    apb_read(4'hc, data, err);
    check_reg(data, 32'h0, "unmapped read data");
    check_reg(cic_pkg::apb_data_t'(err), 32'h1, "pslverr on unmapped read");
    apb_read(cic_pkg::addr_ctrl, data, err);
    check_reg(data, 32'h0000_0005, "ctrl after unmapped write");
    apb_write(cic_pkg::addr_ctrl, 32'h0);
    apb_write(cic_pkg::addr_rate, 32'h0);
  endtask

  task automatic dc_gain_all_rates;
    cic_pkg::sample_t x;
    int               factor;
    for (int r = 0; r < 4; r++)
    begin
      factor = factor_of(cic_pkg::rate_t'(r));
      x      = cic_pkg::sample_t'($urandom);
      apb_write(cic_pkg::addr_rate, cic_pkg::apb_data_t'(r));
      apb_write(cic_pkg::addr_ctrl, 32'h1);
      clear_outputs();
      for (int i = 0; i < factor * dc_outputs; i++)
        send_sample(2'd0, x);
      stop_input();
      wait_outputs(dc_outputs);
      check_count(got_data.size(), dc_outputs, "dc output count");
      for (int k = 0; k < got_data.size(); k++)
      begin
        check_chan(got_chan[k], 2'd0, "dc output channel");
        // first 4 outputs are the step transient
        if (k >= 4)
          check_result(got_data[k], dc_level(x), "dc level");
      end
    end
  endtask

  task automatic output_count;
    // channel 1 at factor 16
    apb_write(cic_pkg::addr_rate, 32'h0000_0004);
    apb_write(cic_pkg::addr_ctrl, 32'h0000_0002);
    clear_outputs();
    for (int i = 0; i < count_samples; i++)
      send_sample(2'd1, cic_pkg::sample_t'($urandom));
    stop_input();
    wait_outputs(count_samples / 16);
    check_count(got_data.size(), count_samples / 16, "outputs per input block");
    for (int k = 0; k < got_chan.size(); k++)
      check_chan(got_chan[k], 2'd1, "count test channel");
  endtask

  task automatic channel_isolation;
    cic_pkg::sample_t level [cic_pkg::n_channels];
    int               seen  [cic_pkg::n_channels];
    cic_pkg::chan_t   ch;
    for (int c = 0; c < cic_pkg::n_channels; c++)
    begin
      level[c] = cic_pkg::sample_t'($urandom);
      seen[c]  = 0;
    end
    // ch0 /32, ch2 /8, ch3 /16, ch1 disabled
    apb_write(cic_pkg::addr_rate, 32'h0000_0060);
    apb_write(cic_pkg::addr_ctrl, 32'h0000_000d);
    clear_outputs();
    for (int i = 0; i < iso_rounds; i++)
    begin
      for (int c = 0; c < cic_pkg::n_channels; c++)
        send_sample(cic_pkg::chan_t'(c), level[c]);
    end
    stop_input();
    wait_outputs(iso_rounds / 32 + iso_rounds / 8 + iso_rounds / 16);
    for (int k = 0; k < got_data.size(); k++)
    begin
      ch = got_chan[k];
      if (ch != 2'd1 && seen[ch] >= 4)
        check_result(got_data[k], dc_level(level[ch]), "per channel level");
      seen[ch]++;
    end
    check_count(seen[0], iso_rounds / 32, "channel 0 outputs");
    check_count(seen[1], 0, "disabled channel 1 outputs");
    check_count(seen[2], iso_rounds / 8, "channel 2 outputs");
    check_count(seen[3], iso_rounds / 16, "channel 3 outputs");
    apb_write(cic_pkg::addr_ctrl, 32'h0);
  endtask

  task automatic backpressure_drop;
    cic_pkg::sample_t   x;
    cic_pkg::sample_t   y;
    cic_pkg::apb_data_t data;
    logic               err;
    x = cic_pkg::sample_t'($urandom);
    y = ~x;
    apb_write(cic_pkg::addr_rate, 32'h0000_0020);
    apb_write(cic_pkg::addr_ctrl, 32'h0000_0004);
    apb_read(cic_pkg::addr_drop, data, err);
    check_reg(data, 32'h0, "drop flags before stall");
    clear_outputs();
    for (int i = 0; i < settle_samples; i++)
      send_sample(2'd2, x);
    stop_input();
    wait_outputs(settle_samples / 8);
    // sink stalls, six results pile into one slot
    @(posedge clock);
    out_ready <= 1'b0;
    clear_outputs();
    for (int i = 0; i < stall_samples; i++)
      send_sample(2'd2, y);
    stop_input();
    apb_read(cic_pkg::addr_drop, data, err);
    check_reg(data, 32'h0000_0004, "drop flag after stall");
    @(posedge clock);
    out_ready <= 1'b1;
    wait_outputs(1);
    check_count(got_data.size(), 1, "outputs after release");
    if (got_data.size() > 0)
    begin
      check_chan(got_chan[0], 2'd2, "released channel");
      check_result(got_data[0], dc_level(y), "released result is the latest");
    end
    apb_write(cic_pkg::addr_drop, 32'h0000_0004);
    apb_read(cic_pkg::addr_drop, data, err);
    check_reg(data, 32'h0, "drop flag after clear");
    apb_write(cic_pkg::addr_ctrl, 32'h0);
  endtask

  // --------------------------------------------------------------------------
  // main sequence
  // --------------------------------------------------------------------------
  initial
  begin
    void'($urandom(32'h18b2_2142));
    arst_n     <= 1'b0;
    psel       <= 1'b0;
    penable    <= 1'b0;
    pwrite     <= 1'b0;
    paddr      <= '0;
    pwdata     <= '0;
    in_valid   <= 1'b0;
    in_channel <= '0;
    in_data    <= '0;
    out_ready  <= 1'b1;
    repeat (4) @(posedge clock);
    arst_n <= 1'b1;
    @(posedge clock);
    register_access();
    dc_gain_all_rates();
    output_count();
    channel_isolation();
    backpressure_drop();
    $display("checks run: %0d, errors: %0d", check_total, error_count);
    if (error_count == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

//--- flist.f
hdl/cic_pkg.sv
hdl/cic_apb_regs.sv
hdl/cic_sample_demux.sv
hdl/cic_decimator.sv
hdl/cic_output_arbiter.sv
hdl/cic_rx_top.sv
dv/cic_arbiter_checker.sv
dv/cic_rx_tb.sv

//--- hdl/cic_apb_regs.sv
// zero wait state APB slave; unmapped addresses read 0 with pslverr, writes there are ignored
`timescale 1ns/10ps

module cic_apb_regs (
  input  logic                clock,
  input  logic                arst_n,
  input  logic                psel,
  input  logic                penable,
  input  logic                pwrite,
  input  cic_pkg::paddr_t     paddr,
  input  cic_pkg::apb_data_t  pwdata,
  output cic_pkg::apb_data_t  prdata,
  output logic                pready,
  output logic                pslverr,
  input  cic_pkg::chan_mask_t drop_pulse,
  output cic_pkg::chan_mask_t enable,
  output cic_pkg::rate_t      rate_0,
  output cic_pkg::rate_t      rate_1,
  output cic_pkg::rate_t      rate_2,
  output cic_pkg::rate_t      rate_3
);

  logic                          access;
  logic                          mapped;
  logic                          wr_en;
  logic [2*cic_pkg::n_channels-1:0] rate_q;
  cic_pkg::chan_mask_t           drop_flags;
  cic_pkg::chan_mask_t           drop_clear;

  // --------------------------------------------------------------------------
  // access decode
  // --------------------------------------------------------------------------
  // access phase of a transfer
  assign access = psel && penable;
  assign mapped = (paddr == cic_pkg::addr_ctrl) ||
                  (paddr == cic_pkg::addr_rate) ||
                  (paddr == cic_pkg::addr_drop);
  assign wr_en  = access && pwrite && mapped;

  // write 1 to clear
  assign drop_clear = (wr_en && (paddr == cic_pkg::addr_drop)) ?
                      pwdata[cic_pkg::n_channels-1:0] : '0;

  // no wait states ever
  assign pready  = 1'b1;
  assign pslverr = access && !mapped;

  // --------------------------------------------------------------------------
  // registers
  // --------------------------------------------------------------------------
  always_ff @(posedge clock or negedge arst_n)
  begin
    if (!arst_n)
    begin
      enable     <= '0;
      rate_q     <= '0;
      drop_flags <= '0;
    end
    else
    begin
      if (wr_en && (paddr == cic_pkg::addr_ctrl))
        enable <= pwdata[cic_pkg::n_channels-1:0];
      if (wr_en && (paddr == cic_pkg::addr_rate))
        rate_q <= pwdata[2*cic_pkg::n_channels-1:0];
      // sticky, a new drop beats a clear in the same cycle
      drop_flags <= (drop_flags & ~drop_clear) | drop_pulse;
    end
  end

  // read mux, zero for holes in the map
  always_comb
  begin
    case (paddr)
      cic_pkg::addr_ctrl: prdata = cic_pkg::apb_data_t'(enable);
      cic_pkg::addr_rate: prdata = cic_pkg::apb_data_t'(rate_q);
      cic_pkg::addr_drop: prdata = cic_pkg::apb_data_t'(drop_flags);
      default:            prdata = '0;
    endcase
  end

  // two bits per channel
  assign rate_0 = rate_q[1:0];
  assign rate_1 = rate_q[3:2];
  assign rate_2 = rate_q[5:4];
  assign rate_3 = rate_q[7:6];

endmodule

//--- hdl/cic_decimator.sv
// one CIC decimator, factor 32/16/8 by rate code; rate changes take effect at once, expect a transient
`timescale 1ns/10ps

module cic_decimator (
  input  logic             clock,
  input  logic             arst_n,
  input  logic             strobe,
  input  cic_pkg::sample_t in_data,
  input  cic_pkg::rate_t   rate,
  output logic             out_strobe,
  output cic_pkg::result_t out_data
);

  cic_pkg::count_t  sample_cnt;
  cic_pkg::count_t  last_cnt;
  logic             dump;
  cic_pkg::acc_t    integ    [cic_pkg::stages];
  cic_pkg::acc_t    comb_dly [cic_pkg::stages];
  cic_pkg::acc_t    comb     [cic_pkg::stages+1];
  cic_pkg::result_t window;
  logic             round_bit;

  // --------------------------------------------------------------------------
  // sample counter
  // --------------------------------------------------------------------------
  // last count value before a dump
  always_comb
  begin
    case (rate)
      cic_pkg::rate_div32: last_cnt = cic_pkg::count_t'(cic_pkg::base_decimation * 4 - 1);
      cic_pkg::rate_div16: last_cnt = cic_pkg::count_t'(cic_pkg::base_decimation * 2 - 1);
      // code 3 folds onto the smallest factor
      default:             last_cnt = cic_pkg::count_t'(cic_pkg::base_decimation - 1);
    endcase
  end

  // at or past the limit, so a lower factor mid-count still dumps
  assign dump = strobe && (sample_cnt >= last_cnt);

  always_ff @(posedge clock or negedge arst_n)
  begin
    if (!arst_n)
    begin
      sample_cnt <= '0;
      out_strobe <= 1'b0;
    end
    else
    begin
      out_strobe <= dump;
      if (dump)
        sample_cnt <= '0;
      else if (strobe)
        sample_cnt <= sample_cnt + 1'b1;
    end
  end

  // --------------------------------------------------------------------------
  // integrators, input rate
  // --------------------------------------------------------------------------
  // wraparound is harmless, combs undo it
  always_ff @(posedge clock or negedge arst_n)
  begin
    if (!arst_n)
    begin
      for (int i = 0; i < cic_pkg::stages; i++)
        integ[i] <= '0;
    end
    else if (strobe)
    begin
      // sign extended input into stage 0
      integ[0] <= integ[0] + cic_pkg::acc_t'(in_data);
      for (int i = 1; i < cic_pkg::stages; i++)
        integ[i] <= integ[i] + integ[i-1];
    end
  end

  // --------------------------------------------------------------------------
  // combs, output rate
  // --------------------------------------------------------------------------
  // subtract chain is combinational, only the delays are registers
  always_comb
  begin
    comb[0] = integ[cic_pkg::stages-1];
    for (int i = 0; i < cic_pkg::stages; i++)
      comb[i+1] = comb[i] - comb_dly[i];
  end

  // delays advance on the same edge that raises out_strobe
  always_ff @(posedge clock or negedge arst_n)
  begin
    if (!arst_n)
    begin
      for (int i = 0; i < cic_pkg::stages; i++)
        comb_dly[i] <= '0;
    end
    else if (dump)
    begin
      for (int i = 0; i < cic_pkg::stages; i++)
        comb_dly[i] <= comb[i];
    end
  end

  // --------------------------------------------------------------------------
  // rounding window
  // --------------------------------------------------------------------------
  // gain is factor**stages, window slides down stages bits per halving
  // so dc gain stays at 2 for every rate
  always_comb
  begin
    case (rate)
      cic_pkg::rate_div32:
      begin
        window    = comb[cic_pkg::stages][cic_pkg::win_lsb +: cic_pkg::out_width];
        round_bit = comb[cic_pkg::stages][cic_pkg::win_lsb-1];
      end
      cic_pkg::rate_div16:
      begin
        window    = comb[cic_pkg::stages][cic_pkg::win_lsb-cic_pkg::stages +: cic_pkg::out_width];
        round_bit = comb[cic_pkg::stages][cic_pkg::win_lsb-cic_pkg::stages-1];
      end
      // codes 2 and 3
      default:
      begin
        window    = comb[cic_pkg::stages][cic_pkg::win_lsb-2*cic_pkg::stages +: cic_pkg::out_width];
        round_bit = comb[cic_pkg::stages][cic_pkg::win_lsb-2*cic_pkg::stages-1];
      end
    endcase
  end

  // round half up, valid while out_strobe is high
  always_ff @(posedge clock)
  begin
    if (dump)
      out_data <= window + cic_pkg::result_t'(round_bit);
  end

endmodule

//--- hdl/cic_output_arbiter.sv
// round-robin merge; results wait in holding regs while out_ready is low, newest result wins
`timescale 1ns/10ps

module cic_output_arbiter (
  input  logic                clock,
  input  logic                arst_n,
  input  cic_pkg::chan_mask_t res_strobe,
  input  cic_pkg::result_t    res_data [cic_pkg::n_channels],
  output logic                out_valid,
  input  logic                out_ready,
  output cic_pkg::chan_t      out_channel,
  output cic_pkg::result_t    out_data,
  output cic_pkg::chan_mask_t drop_pulse
);

  cic_pkg::chan_mask_t full;
  cic_pkg::result_t    hold [cic_pkg::n_channels];
  cic_pkg::chan_t      last_chan;
  cic_pkg::chan_t      grant;
  logic                grant_valid;
  logic                load;
  cic_pkg::chan_mask_t take;

  // --------------------------------------------------------------------------
  // round robin pick
  // --------------------------------------------------------------------------
  // search starts one past the channel served last
  always_comb
  begin : rr_search
    cic_pkg::chan_t idx;
    grant_valid = 1'b0;
    grant       = last_chan;
    for (int k = 1; k <= cic_pkg::n_channels; k++)
    begin
      idx = cic_pkg::chan_t'(last_chan + k);
      if (!grant_valid && full[idx])
      begin
        grant_valid = 1'b1;
        grant       = idx;
      end
    end
  end

  // move only when the sink can take, so a stall leaves results in hold
  assign load = out_ready && grant_valid;
  assign take = load ? (cic_pkg::chan_mask_t'(1) << grant) : '0;

  // overwrite of a full slot not drained this cycle
  assign drop_pulse = res_strobe & full & ~take;

  always_ff @(posedge clock or negedge arst_n)
  begin
    if (!arst_n)
    begin
      full      <= '0;
      out_valid <= 1'b0;
      last_chan <= cic_pkg::chan_t'(cic_pkg::n_channels - 1);
    end
    else
    begin
      // a new result keeps the slot full even if drained now
      full <= (full & ~take) | res_strobe;
      if (out_ready)
        out_valid <= grant_valid;
      if (load)
        last_chan <= grant;
    end
  end

  // payload
  always_ff @(posedge clock)
  begin
    for (int i = 0; i < cic_pkg::n_channels; i++)
    begin
      if (res_strobe[i])
        hold[i] <= res_data[i];
    end
    if (load)
    begin
      out_channel <= grant;
      out_data    <= hold[grant];
    end
  end

endmodule

//--- hdl/cic_pkg.sv
// shared widths and codes; n_channels must equal 2**chan_width, acc_width must cover in_width+stages*5
package cic_pkg;

  // ------------------------------------------------------------------------
  // channel layout
  // ------------------------------------------------------------------------
  localparam int n_channels = 4;
  localparam int chan_width = 2;

  // filter shape, factor is base_decimation times 1, 2 or 4
  localparam int stages          = 3;
  localparam int base_decimation = 8;
  localparam int max_decimation  = base_decimation * 4;
  localparam int cnt_width       = $clog2(max_decimation);

  // datapath widths
  localparam int in_width  = 16;
  localparam int acc_width = 32;
  localparam int out_width = 18;
  // lsb of output window at factor 32
  localparam int win_lsb   = acc_width - out_width;

  typedef logic signed [in_width-1:0]  sample_t;
  typedef logic signed [acc_width-1:0] acc_t;
  typedef logic signed [out_width-1:0] result_t;
  typedef logic [chan_width-1:0]       chan_t;
  typedef logic [1:0]                  rate_t;
  typedef logic [n_channels-1:0]       chan_mask_t;
  typedef logic [cnt_width-1:0]        count_t;
  typedef logic [3:0]                  paddr_t;
  typedef logic [31:0]                 apb_data_t;

  // rate codes, code 3 behaves as rate_div8
  localparam rate_t rate_div32 = 2'd0;
  localparam rate_t rate_div16 = 2'd1;
  localparam rate_t rate_div8  = 2'd2;

  // register map
  localparam paddr_t addr_ctrl = 4'h0;
  localparam paddr_t addr_rate = 4'h4;
  localparam paddr_t addr_drop = 4'h8;

endpackage

//--- hdl/cic_rx_top.sv
// four-channel CIC receiver; single clock, tagged input without back-pressure, APB for config only
`timescale 1ns/10ps

module cic_rx_top (
  input  logic               clock,
  input  logic               arst_n,
  // apb config port
  input  logic               psel,
  input  logic               penable,
  input  logic               pwrite,
  input  cic_pkg::paddr_t    paddr,
  input  cic_pkg::apb_data_t pwdata,
  output cic_pkg::apb_data_t prdata,
  output logic               pready,
  output logic               pslverr,
  // tagged sample stream
  input  logic               in_valid,
  input  cic_pkg::chan_t     in_channel,
  input  cic_pkg::sample_t   in_data,
  // merged result stream
  output logic               out_valid,
  input  logic               out_ready,
  output cic_pkg::chan_t     out_channel,
  output cic_pkg::result_t   out_data
);

  cic_pkg::chan_mask_t enable;
  cic_pkg::chan_mask_t strobe;
  cic_pkg::chan_mask_t res_strobe;
  cic_pkg::chan_mask_t drop_pulse;
  cic_pkg::rate_t      rate     [cic_pkg::n_channels];
  cic_pkg::sample_t    chan_data;
  cic_pkg::result_t    res_data [cic_pkg::n_channels];

  // --------------------------------------------------------------------------
  // config
  // --------------------------------------------------------------------------
  cic_apb_regs i_cic_apb_regs (
    .clock      (clock),
    .arst_n     (arst_n),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .prdata     (prdata),
    .pready     (pready),
    .pslverr    (pslverr),
    .drop_pulse (drop_pulse),
    .enable     (enable),
    .rate_0     (rate[0]),
    .rate_1     (rate[1]),
    .rate_2     (rate[2]),
    .rate_3     (rate[3])
  );

  // --------------------------------------------------------------------------
  // datapath
  // --------------------------------------------------------------------------
  cic_sample_demux i_cic_sample_demux (
    .clock      (clock),
    .arst_n     (arst_n),
    .in_valid   (in_valid),
    .in_channel (in_channel),
    .in_data    (in_data),
    .enable     (enable),
    .strobe     (strobe),
    .chan_data  (chan_data)
  );

  // one decimator per channel, shared input data
  for (genvar i = 0; i < cic_pkg::n_channels; i++)
  begin : g_chan
    cic_decimator i_cic_decimator (
      .clock      (clock),
      .arst_n     (arst_n),
      .strobe     (strobe[i]),
      .in_data    (chan_data),
      .rate       (rate[i]),
      .out_strobe (res_strobe[i]),
      .out_data   (res_data[i])
    );
  end

  cic_output_arbiter i_cic_output_arbiter (
    .clock       (clock),
    .arst_n      (arst_n),
    .res_strobe  (res_strobe),
    .res_data    (res_data),
    .out_valid   (out_valid),
    .out_ready   (out_ready),
    .out_channel (out_channel),
    .out_data    (out_data),
    .drop_pulse  (drop_pulse)
  );

endmodule

//--- hdl/cic_sample_demux.sv
// input stream cannot stall; samples for disabled channels are dropped silently
`timescale 1ns/10ps

module cic_sample_demux (
  input  logic                clock,
  input  logic                arst_n,
  input  logic                in_valid,
  input  cic_pkg::chan_t      in_channel,
  input  cic_pkg::sample_t    in_data,
  input  cic_pkg::chan_mask_t enable,
  output cic_pkg::chan_mask_t strobe,
  output cic_pkg::sample_t    chan_data
);

  cic_pkg::chan_mask_t chan_hot;

  // one-hot of the tagged channel
  assign chan_hot = cic_pkg::chan_mask_t'(1) << in_channel;

  // --------------------------------------------------------------------------
  // strobe, one cycle after in_valid
  // --------------------------------------------------------------------------
  always_ff @(posedge clock or negedge arst_n)
  begin
    if (!arst_n)
      strobe <= '0;
    else if (in_valid)
      strobe <= chan_hot & enable;
    else
      strobe <= '0;
  end

  // single data copy shared by all decimators
  // only the strobed channel looks at it
  always_ff @(posedge clock)
  begin
    if (in_valid)
      chan_data <= in_data;
  end

endmodule

//--- run.sh
#!/bin/sh
# build with Verilator and run the testbench, verdict comes from sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal --top-module cic_rx_tb \
  -f flist.f -o cic_rx_sim > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/cic_rx_sim > sim.log 2>&1
grep -q "Simulation failed" sim.log && { echo "FAIL, see sim.log"; exit 1; }
grep -q "Simulation completed successfully" sim.log || { echo "FAIL, run ended early"; exit 1; }
echo "PASS"
